// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sonata -f vlog.f
./obj_dir/Vtb_sonata > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// ==== sonata_bus_decode.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module sonata_bus_decode (
  input  logic                              clk_sys_i,
  input  logic                              rst_n_i,
  input  sonata_bus_pkg::bus_req_t          bus_req_i,
  output sonata_bus_pkg::bus_rsp_t          bus_rsp_o,
  output sonata_bus_pkg::dev_req_t          gpio_req_o,
  output sonata_bus_pkg::dev_req_t          pwm_req_o,
  output sonata_bus_pkg::dev_req_t          timer_req_o,
  input  logic [`SONATA_BUS_DATA_WIDTH-1:0] gpio_rdata_i,
  input  logic [`SONATA_BUS_DATA_WIDTH-1:0] pwm_rdata_i,
  input  logic [`SONATA_BUS_DATA_WIDTH-1:0] timer_rdata_i
);
  import sonata_bus_pkg::*;

  logic [3:0]                        dev_idx;
  logic                              base_hit;
  logic                              dev_hit;
  logic                              acc_ok;
  dev_req_t                          dev_req;    // Shared fields for all devices
  logic                              rvalid_q;
  logic                              err_q;
  logic [3:0]                        dev_sel_q;
  logic [`SONATA_BUS_DATA_WIDTH-1:0] rdata_mux;

  ////////////////////////////////////////////////////////////////////////////
  // Request side

  assign dev_idx  = bus_req_i.addr[15:12];
  assign base_hit = bus_req_i.addr[31:16] == `SONATA_PERIPH_BASE;
  assign dev_hit  = (dev_idx == 4'(`SONATA_DEV_GPIO)) ||
                    (dev_idx == 4'(`SONATA_DEV_PWM))  ||
                    (dev_idx == 4'(`SONATA_DEV_TIMER));
  assign acc_ok   = base_hit & dev_hit;

  always_comb begin
    dev_req.req    = bus_req_i.req & acc_ok;
    dev_req.we     = bus_req_i.we;
    dev_req.be     = bus_req_i.be;
    dev_req.offset = bus_req_i.addr[`SONATA_REG_ADDR_WIDTH-1:0];
    dev_req.wdata  = bus_req_i.wdata;
  end

  // One device at most sees req
  always_comb begin
    gpio_req_o      = dev_req;
    gpio_req_o.req  = dev_req.req & (dev_idx == 4'(`SONATA_DEV_GPIO));
    pwm_req_o       = dev_req;
    pwm_req_o.req   = dev_req.req & (dev_idx == 4'(`SONATA_DEV_PWM));
    timer_req_o     = dev_req;
    timer_req_o.req = dev_req.req & (dev_idx == 4'(`SONATA_DEV_TIMER));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side, always the cycle after the request

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      err_q    <= bus_req_i.req & ~acc_ok;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_req_i.req) dev_sel_q <= dev_idx;
  end

  always_comb begin
    case (dev_sel_q)
      4'(`SONATA_DEV_GPIO):  rdata_mux = gpio_rdata_i;
      4'(`SONATA_DEV_PWM):   rdata_mux = pwm_rdata_i;
      4'(`SONATA_DEV_TIMER): rdata_mux = timer_rdata_i;
      default:               rdata_mux = '0;
    endcase
  end

  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.err    = err_q;
  assign bus_rsp_o.rdata  = err_q ? '0 : rdata_mux;  // Zero on decode error

endmodule

// ==== sonata_bus_pkg.sv ====
`include "sonata_settings.svh"

package sonata_bus_pkg;

  // Host request, a single-cycle strobe
  typedef struct packed {
    logic                              req;
    logic                              we;
    logic [`SONATA_BUS_BE_WIDTH-1:0]   be;
    logic [`SONATA_BUS_ADDR_WIDTH-1:0] addr;
    logic [`SONATA_BUS_DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                              rvalid;
    logic [`SONATA_BUS_DATA_WIDTH-1:0] rdata;
    logic                              err;    // Decode error
  } bus_rsp_t;

  // Access as one device sees it
  typedef struct packed {
    logic                              req;    // Qualified for this device only
    logic                              we;
    logic [`SONATA_BUS_BE_WIDTH-1:0]   be;
    logic [`SONATA_REG_ADDR_WIDTH-1:0] offset;
    logic [`SONATA_BUS_DATA_WIDTH-1:0] wdata;
  } dev_req_t;

  // Byte-lane write merge
  function automatic logic [`SONATA_BUS_DATA_WIDTH-1:0] be_merge(
    input logic [`SONATA_BUS_DATA_WIDTH-1:0] old_word,
    input logic [`SONATA_BUS_DATA_WIDTH-1:0] new_word,
    input logic [`SONATA_BUS_BE_WIDTH-1:0]   be
  );
    logic [`SONATA_BUS_DATA_WIDTH-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `SONATA_BUS_BE_WIDTH; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

// ==== sonata_gpio.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module sonata_gpio (
  input  logic                              clk_sys_i,
  input  logic                              rst_n_i,
  input  sonata_bus_pkg::dev_req_t          dev_req_i,
  output logic [`SONATA_BUS_DATA_WIDTH-1:0] rdata_o,
  input  logic [`SONATA_GPI_WIDTH-1:0]      gp_i,
  output logic [`SONATA_GPO_WIDTH-1:0]      gp_o
);
  import sonata_bus_pkg::*;

  localparam int unsigned dw = `SONATA_BUS_DATA_WIDTH;
  localparam int unsigned gpo_w = `SONATA_GPO_WIDTH;
  localparam int unsigned gpi_w = `SONATA_GPI_WIDTH;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_gpo = 'h0;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_gpi = 'h4;

  logic [gpo_w-1:0] gpo_q;
  logic [gpo_w-1:0] gpo_d;
  logic [dw-1:0]    gpo_word;
  logic             gpo_wr;
  logic [gpi_w-1:0] gpi_meta_q;
  logic [gpi_w-1:0] gpi_sync_q;

  assign gpo_wr   = dev_req_i.req & dev_req_i.we & (dev_req_i.offset == off_gpo);
  assign gpo_word = be_merge({{(dw-gpo_w){1'b0}}, gpo_q}, dev_req_i.wdata, dev_req_i.be);
  assign gpo_d    = gpo_wr ? gpo_word[gpo_w-1:0] : gpo_q;  // Upper byte dropped

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpo_q      <= gpo_d;
      gpi_meta_q <= gp_i;       // Two-stage synchroniser
      gpi_sync_q <= gpi_meta_q;
    end
  end

  // Read word reflects a write in the same access
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      case (dev_req_i.offset)
        off_gpo: rdata_o <= {{(dw-gpo_w){1'b0}}, gpo_d};
        off_gpi: rdata_o <= {{(dw-gpi_w){1'b0}}, gpi_sync_q};
        default: rdata_o <= '0;
      endcase
    end
  end

  assign gp_o = gpo_q;

endmodule

// ==== sonata_periph_pkg.sv ====
`include "sonata_settings.svh"

package sonata_periph_pkg;

  // Bus view of a 64-bit timer word
  typedef struct packed {
    logic [`SONATA_BUS_DATA_WIDTH-1:0] hi;
    logic [`SONATA_BUS_DATA_WIDTH-1:0] lo;
  } timer_half_t;

  // Same word, compared whole or accessed in halves
  typedef union packed {
    logic [2*`SONATA_BUS_DATA_WIDTH-1:0] word;
    timer_half_t                         half;
  } timer_word_u;

  typedef struct packed {
    logic [`SONATA_PWM_CTR_SIZE-1:0] period;  // High byte
    logic [`SONATA_PWM_CTR_SIZE-1:0] duty;    // Low byte
  } pwm_chan_t;

endpackage

// ==== sonata_pwm.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module sonata_pwm (
  input  logic                              clk_sys_i,
  input  logic                              rst_n_i,
  input  sonata_bus_pkg::dev_req_t          dev_req_i,
  output logic [`SONATA_BUS_DATA_WIDTH-1:0] rdata_o,
  output logic [`SONATA_PWM_WIDTH-1:0]      pwm_o
);
  import sonata_bus_pkg::*;
  import sonata_periph_pkg::*;

  localparam int unsigned dw = `SONATA_BUS_DATA_WIDTH;
  localparam int unsigned nchan = `SONATA_PWM_WIDTH;
  localparam int unsigned csize = `SONATA_PWM_CTR_SIZE;
  localparam int unsigned cw = $bits(pwm_chan_t);
  localparam int unsigned idx_w = `SONATA_REG_ADDR_WIDTH - 2;

  pwm_chan_t        chan_q [nchan];
  logic [csize-1:0] ctr_q  [nchan];
  logic [idx_w-1:0] chan_idx;
  logic             chan_hit;
  logic             chan_wr;
  pwm_chan_t        chan_cur;
  pwm_chan_t        chan_new;
  logic [dw-1:0]    chan_word;

  // One word per channel, word aligned
  assign chan_idx = dev_req_i.offset[`SONATA_REG_ADDR_WIDTH-1:2];
  assign chan_hit = (dev_req_i.offset[1:0] == 2'b00) && (chan_idx < nchan);
  assign chan_wr  = dev_req_i.req & dev_req_i.we & chan_hit;

  always_comb begin
    chan_cur = '0;
    for (int c = 0; c < nchan; c++) begin
      if (chan_idx == c) chan_cur = chan_q[c];
    end
  end

  assign chan_word = be_merge({{(dw-cw){1'b0}}, chan_cur}, dev_req_i.wdata, dev_req_i.be);
  assign chan_new  = chan_word[cw-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Channel registers and counters

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < nchan; c++) begin
        chan_q[c] <= '0;
        ctr_q[c]  <= '0;
      end
    end else begin
      for (int c = 0; c < nchan; c++) begin
        if (chan_wr && (chan_idx == c)) begin
          chan_q[c] <= chan_new;
          ctr_q[c]  <= '0;                      // Restart on reload
        end else if (ctr_q[c] == chan_q[c].period) begin
          ctr_q[c]  <= '0;
        end else begin
          ctr_q[c]  <= ctr_q[c] + 1'b1;
        end
      end
    end
  end

  for (genvar c = 0; c < nchan; c++) begin : gen_out
    assign pwm_o[c] = ctr_q[c] < chan_q[c].duty;  // High for the first duty counts
  end

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      if (chan_hit) rdata_o <= {{(dw-cw){1'b0}}, (chan_wr ? chan_new : chan_cur)};
      else          rdata_o <= '0;
    end
  end

endmodule

// ==== sonata_settings.svh ====
`ifndef SONATA_SETTINGS_SVH
`define SONATA_SETTINGS_SVH

// Register bus widths
`define SONATA_BUS_ADDR_WIDTH 32
`define SONATA_BUS_DATA_WIDTH 32
`define SONATA_BUS_BE_WIDTH   4
`define SONATA_REG_ADDR_WIDTH 8   // Offset seen by a device

// Peripheral window, address bits 31 to 16
`define SONATA_PERIPH_BASE 16'h8000

// Device index in address bits 15 to 12
`define SONATA_DEV_GPIO  0
`define SONATA_DEV_PWM   1
`define SONATA_DEV_TIMER 2

// Pin counts
`define SONATA_GPI_WIDTH 13
`define SONATA_GPO_WIDTH 24
`define SONATA_PWM_WIDTH 12

`define SONATA_PWM_CTR_SIZE 8   // Counter, duty and period

`endif

// ==== sonata_system.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module sonata_system (
  input  logic                         clk_sys_i,
  input  logic                         rst_n_i,
  input  sonata_bus_pkg::bus_req_t     bus_req_i,
  output sonata_bus_pkg::bus_rsp_t     bus_rsp_o,
  input  logic [`SONATA_GPI_WIDTH-1:0] gp_i,
  output logic [`SONATA_GPO_WIDTH-1:0] gp_o,
  output logic [`SONATA_PWM_WIDTH-1:0] pwm_o,
  output logic                         timer_irq_o
);
  import sonata_bus_pkg::*;

  // Per-device request and read data
  dev_req_t                          gpio_req;
  dev_req_t                          pwm_req;
  dev_req_t                          timer_req;
  logic [`SONATA_BUS_DATA_WIDTH-1:0] gpio_rdata;
  logic [`SONATA_BUS_DATA_WIDTH-1:0] pwm_rdata;
  logic [`SONATA_BUS_DATA_WIDTH-1:0] timer_rdata;

  sonata_bus_decode u_bus_decode (
    .clk_sys_i     (clk_sys_i),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .gpio_req_o    (gpio_req),
    .pwm_req_o     (pwm_req),
    .timer_req_o   (timer_req),
    .gpio_rdata_i  (gpio_rdata),
    .pwm_rdata_i   (pwm_rdata),
    .timer_rdata_i (timer_rdata)
  );

  sonata_gpio u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_n_i   (rst_n_i),
    .dev_req_i (gpio_req),
    .rdata_o   (gpio_rdata),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  sonata_pwm u_pwm (
    .clk_sys_i (clk_sys_i),
    .rst_n_i   (rst_n_i),
    .dev_req_i (pwm_req),
    .rdata_o   (pwm_rdata),
    .pwm_o     (pwm_o)
  );

  sonata_timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .dev_req_i   (timer_req),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== sonata_timer.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module sonata_timer (
  input  logic                              clk_sys_i,
  input  logic                              rst_n_i,
  input  sonata_bus_pkg::dev_req_t          dev_req_i,
  output logic [`SONATA_BUS_DATA_WIDTH-1:0] rdata_o,
  output logic                              timer_irq_o
);
  import sonata_bus_pkg::*;
  import sonata_periph_pkg::*;

  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_cnt_lo = 'h00;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_cnt_hi = 'h04;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_cmp_lo = 'h08;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_cmp_hi = 'h0c;
  localparam logic [`SONATA_REG_ADDR_WIDTH-1:0] off_ctrl   = 'h10;

  timer_word_u                       cnt_q;
  timer_word_u                       cnt_d;
  timer_word_u                       cmp_q;
  timer_word_u                       cmp_d;
  logic                              en_q;
  logic                              en_d;
  logic                              irq_q;
  logic                              wr;
  logic [`SONATA_BUS_DATA_WIDTH-1:0] rd_word;

  assign wr = dev_req_i.req & dev_req_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    cnt_d = cnt_q;
    cmp_d = cmp_q;
    en_d  = en_q;
    if (en_q) cnt_d.word = cnt_q.word + 1'b1;

    if (wr) begin
      case (dev_req_i.offset)
        off_cnt_lo: begin
          cnt_d = cnt_q;   // A counter write holds off the increment
          cnt_d.half.lo = be_merge(cnt_q.half.lo, dev_req_i.wdata, dev_req_i.be);
        end
        off_cnt_hi: begin
          cnt_d = cnt_q;
          cnt_d.half.hi = be_merge(cnt_q.half.hi, dev_req_i.wdata, dev_req_i.be);
        end
        off_cmp_lo: cmp_d.half.lo = be_merge(cmp_q.half.lo, dev_req_i.wdata, dev_req_i.be);
        off_cmp_hi: cmp_d.half.hi = be_merge(cmp_q.half.hi, dev_req_i.wdata, dev_req_i.be);
        off_ctrl:   if (dev_req_i.be[0]) en_d = dev_req_i.wdata[0];
        default: ;
      endcase
    end
  end

  // Read mux
  always_comb begin
    case (dev_req_i.offset)
      off_cnt_lo: rd_word = cnt_d.half.lo;
      off_cnt_hi: rd_word = cnt_d.half.hi;
      off_cmp_lo: rd_word = cmp_d.half.lo;
      off_cmp_hi: rd_word = cmp_d.half.hi;
      off_ctrl:   rd_word = {{(`SONATA_BUS_DATA_WIDTH-1){1'b0}}, en_d};
      default:    rd_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q.word <= '0;
      cmp_q.word <= '1;   // No interrupt until compare is set
      en_q       <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      cmp_q <= cmp_d;
      en_q  <= en_d;
      irq_q <= cnt_q.word >= cmp_q.word;  // Full 64-bit compare
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) rdata_o <= rd_word;
  end

  assign timer_irq_o = irq_q;

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module tb_checker (
  input  logic                         clk_sys_i,
  input  logic                         rst_n_i,
  input  sonata_bus_pkg::bus_req_t     bus_req_i,
  input  sonata_bus_pkg::bus_rsp_t     bus_rsp_i,
  input  logic [`SONATA_GPI_WIDTH-1:0] gpi_i,
  input  logic [`SONATA_GPO_WIDTH-1:0] gpo_i,
  input  logic [`SONATA_PWM_WIDTH-1:0] pwm_i,
  input  logic                         irq_i,
  input  int                           test_idx_i,
  input  logic                         test_end_i,
  input  logic                         run_end_i,
  output int                           err_cnt_o
);
  import sonata_bus_pkg::*;

  localparam int nchan = `SONATA_PWM_WIDTH;

  // Shadow of the device registers
  logic [`SONATA_GPO_WIDTH-1:0] gpo_s;
  logic [`SONATA_GPI_WIDTH-1:0] gpi_d1;
  logic [`SONATA_GPI_WIDTH-1:0] gpi_d2;
  logic [15:0]                  pwm_s [nchan];
  logic [63:0]                  cnt_s;
  logic [63:0]                  cmp_s;
  logic                         en_s;
  logic                         irq_exp;
  // Request in flight
  logic                         req_d1;
  logic                         loose_d1;
  logic [32:0]                  exp_d1;
  logic [31:0]                  addr_d1;
  // PWM measuring window and the run after timer enable
  int                           pwm_ch;
  int                           pwm_left;
  int                           pwm_high;
  int                           pwm_want;
  int                           tmr_k;
  int                           tmr_gap;
  int                           chk_cnt = 0;
  int                           err_cnt = 0;
  int                           chk_mark = 0;
  int                           err_mark = 0;

  assign err_cnt_o = err_cnt;

  task automatic flag_mismatch(input string msg);
    err_cnt++;
    $display("FAIL %0t ns: %s", $time, msg);
  endtask

  task automatic protocol_error(input string msg);
    err_cnt++;
    $display("Bus protocol error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = be[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model giving {err, rdata} from the shadow before the access lands

  function automatic logic [32:0] expect_rsp(input bus_req_t r);
    logic [7:0]  off;
    logic [31:0] d;
    int          ch;
    off = r.addr[7:0];
    ch  = int'(off[7:2]);
    d   = '0;
    if (r.addr[31:16] != `SONATA_PERIPH_BASE) return {1'b1, 32'h0};
    case (int'(r.addr[15:12]))
      `SONATA_DEV_GPIO: begin
        if (off == 8'h00) begin
          d = r.we ? merge_bytes(32'(gpo_s), r.wdata, r.be) : 32'(gpo_s);
          d = d & ((32'h1 << `SONATA_GPO_WIDTH) - 1);   // Top byte not stored
        end else if (off == 8'h04) begin
          d = 32'(gpi_d2);
        end
      end
      `SONATA_DEV_PWM: begin
        if (off[1:0] == 2'b00 && ch < nchan) begin
          d = 32'(pwm_s[ch]);
          if (r.we) begin
            d = merge_bytes(d, r.wdata, r.be);
            d[31:16] = '0;
          end
        end
      end
      `SONATA_DEV_TIMER: begin
        case (off)
          8'h00:   d = cnt_s[31:0];
          8'h04:   d = cnt_s[63:32];
          8'h08:   d = cmp_s[31:0];
          8'h0c:   d = cmp_s[63:32];
          8'h10:   d = {31'h0, en_s};
          default: d = '0;
        endcase
        if (r.we && off <= 8'h0c && off[1:0] == 2'b00) d = merge_bytes(d, r.wdata, r.be);
        if (r.we && off == 8'h10 && r.be[0]) d = {31'h0, r.wdata[0]};
        if (en_s && !r.we && off == 8'h00) d = cnt_s[31:0] + 32'd1;  // Lower bound only
      end
      default: return {1'b1, 32'h0};
    endcase
    return {1'b0, d};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Monitor

  always @(posedge clk_sys_i or negedge rst_n_i) begin : monitor
    logic [32:0] rsp_now;
    logic        loose_now;
    logic [7:0]  off;
    int          ch;
    if (!rst_n_i) begin
      gpo_s    <= '0;
      gpi_d1   <= '0;
      gpi_d2   <= '0;
      for (int c = 0; c < nchan; c++) pwm_s[c] <= '0;
      cnt_s    <= '0;
      cmp_s    <= '1;
      en_s     <= 1'b0;
      irq_exp  <= 1'b0;
      req_d1   <= 1'b0;
      loose_d1 <= 1'b0;
      exp_d1   <= '0;
      addr_d1  <= '0;
      pwm_ch   <= 0;
      pwm_left <= 0;
      pwm_high <= 0;
      pwm_want <= 0;
      tmr_k    <= 0;
      tmr_gap  <= 0;
    end else begin
      rsp_now   = expect_rsp(bus_req_i);
      off       = bus_req_i.addr[7:0];
      ch        = int'(off[7:2]);
      loose_now = en_s && !bus_req_i.we && !rsp_now[32] &&
                  bus_req_i.addr[15:12] == 4'(`SONATA_DEV_TIMER) && off == 8'h00;
      gpi_d1  <= gpi_i;
      gpi_d2  <= gpi_d1;
      irq_exp <= cnt_s >= cmp_s;

      // Response must follow its request by exactly one cycle
      if (bus_rsp_i.rvalid && !req_d1) begin
        protocol_error("rvalid came without a request in the cycle before");
      end else if (!bus_rsp_i.rvalid && req_d1) begin
        protocol_error($sformatf("no rvalid for the request to %h", addr_d1));
      end else if (req_d1) begin
        chk_cnt++;
        if (bus_rsp_i.err != exp_d1[32])
          flag_mismatch($sformatf("addr %h err %0b, expected %0b",
                                  addr_d1, bus_rsp_i.err, exp_d1[32]));
        else if (loose_d1 ? bus_rsp_i.rdata < exp_d1[31:0] : bus_rsp_i.rdata != exp_d1[31:0])
          flag_mismatch($sformatf("addr %h rdata %h, expected %s%h", addr_d1,
                                  bus_rsp_i.rdata, loose_d1 ? "at least " : "", exp_d1[31:0]));
      end
      req_d1 <= bus_req_i.req;
      if (bus_req_i.req) begin
        exp_d1   <= rsp_now;
        loose_d1 <= loose_now;
        addr_d1  <= bus_req_i.addr;
      end

      chk_cnt++;
      if (gpo_i != gpo_s) flag_mismatch($sformatf("gp_o %h, expected %h", gpo_i, gpo_s));

      if (!en_s) begin
        chk_cnt++;
        if (irq_i != irq_exp) flag_mismatch($sformatf("timer_irq_o %0b, expected %0b",
                                                      irq_i, irq_exp));
      end else begin
        tmr_k <= tmr_k + 1;
        if (tmr_k + 1 <= tmr_gap - 2 && irq_i)
          flag_mismatch($sformatf("timer_irq_o high %0d cycles after enable, gap %0d",
                                  tmr_k + 1, tmr_gap));
        if (tmr_k + 1 == tmr_gap + 3) begin
          chk_cnt++;
          if (!irq_i) flag_mismatch($sformatf("timer_irq_o still low, gap %0d", tmr_gap));
        end
      end

      // High cycles over one full period
      if (pwm_left > 0) begin
        pwm_left <= pwm_left - 1;
        pwm_high <= pwm_high + int'(pwm_i[pwm_ch]);
        if (pwm_left == 1) begin
          chk_cnt++;
          if (pwm_high + int'(pwm_i[pwm_ch]) != pwm_want)
            flag_mismatch($sformatf("pwm_o[%0d] high for %0d cycles, expected %0d",
                                    pwm_ch, pwm_high + int'(pwm_i[pwm_ch]), pwm_want));
        end
      end

      if (bus_req_i.req && bus_req_i.we && !rsp_now[32]) begin
        case (int'(bus_req_i.addr[15:12]))
          `SONATA_DEV_GPIO: if (off == 8'h00) gpo_s <= rsp_now[`SONATA_GPO_WIDTH-1:0];
          `SONATA_DEV_PWM: begin
            if (off[1:0] == 2'b00 && ch < nchan) begin
              pwm_s[ch] <= rsp_now[15:0];
              pwm_ch    <= ch;
              pwm_left  <= int'(rsp_now[15:8]) + 1;
              pwm_high  <= 0;
              pwm_want  <= (int'(rsp_now[7:0]) <= int'(rsp_now[15:8])) ?
                           int'(rsp_now[7:0]) : int'(rsp_now[15:8]) + 1;
            end
          end
          `SONATA_DEV_TIMER: begin
            case (off)
              8'h00: cnt_s[31:0]  <= rsp_now[31:0];
              8'h04: cnt_s[63:32] <= rsp_now[31:0];
              8'h08: cmp_s[31:0]  <= rsp_now[31:0];
              8'h0c: cmp_s[63:32] <= rsp_now[31:0];
              8'h10: begin
                if (bus_req_i.be[0]) begin
                  en_s <= bus_req_i.wdata[0];
                  if (bus_req_i.wdata[0] && !en_s) begin
                    tmr_k   <= 0;
                    tmr_gap <= int'(cmp_s - cnt_s);
                  end
                end
              end
              default: ;
            endcase
          end
          default: ;
        endcase
      end

      if (test_end_i) begin
        $display("Test %0d done: %0d checks, %0d errors", test_idx_i,
                 chk_cnt - chk_mark, err_cnt - err_mark);
        chk_mark = chk_cnt;
        err_mark = err_cnt;
      end
      if (run_end_i) $display("All tests: %0d checks, %0d errors", chk_cnt, err_cnt);
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period_ns  = 40,
  parameter int rst_cycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== tb_sonata.sv ====
`timescale 1ns/1ns
`include "sonata_settings.svh"

module tb_sonata;
  import sonata_bus_pkg::*;

  localparam int n_gpo      = 16;
  localparam int n_gpi      = 8;
  localparam int n_err      = 6;
  localparam int n_pwm      = 8;
  localparam int n_tmr      = 8;
  localparam int n_items    = n_gpo + n_gpi + n_err + n_pwm + n_tmr + 1;
  localparam int item_bound = 400;   // Cycles, longest PWM window fits
  localparam int clk_period = 40;
  localparam int rst_cycles = 16;
  localparam int limit_ns   = (rst_cycles + n_items * item_bound) * clk_period;

  logic                         clk_sys;
  logic                         rst_n;
  bus_req_t                     bus_req;
  bus_rsp_t                     bus_rsp;
  logic [`SONATA_GPI_WIDTH-1:0] gpi;
  logic [`SONATA_GPO_WIDTH-1:0] gpo;
  logic [`SONATA_PWM_WIDTH-1:0] pwm;
  logic                         timer_irq;
  int                           test_idx;
  logic                         test_end;
  logic                         run_end;
  int                           err_cnt;
  logic [31:0]                  seed;

  tb_clk_gen #(
    .period_ns  (clk_period),
    .rst_cycles (rst_cycles)
  ) u_clk_gen (
    .clk_o   (clk_sys),
    .rst_n_o (rst_n)
  );

  sonata_system uut (
    .clk_sys_i   (clk_sys),
    .rst_n_i     (rst_n),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .gp_i        (gpi),
    .gp_o        (gpo),
    .pwm_o       (pwm),
    .timer_irq_o (timer_irq)
  );

  tb_checker u_checker (
    .clk_sys_i  (clk_sys),
    .rst_n_i    (rst_n),
    .bus_req_i  (bus_req),
    .bus_rsp_i  (bus_rsp),
    .gpi_i      (gpi),
    .gpo_i      (gpo),
    .pwm_i      (pwm),
    .irq_i      (timer_irq),
    .test_idx_i (test_idx),
    .test_end_i (test_end),
    .run_end_i  (run_end),
    .err_cnt_o  (err_cnt)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [31:0] next_rand();
    seed = lcg_step(seed);
    return {seed[15:0], seed[31:16]};   // Low LCG bits are weak
  endfunction

  function automatic logic [31:0] reg_addr(input int dev, input int off);
    return {`SONATA_PERIPH_BASE, 4'(dev), 4'h0, 8'(off)};
  endfunction

  task automatic send_req(input logic we, input logic [3:0] be,
                          input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk_sys);
    bus_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_sys);
      bus_req <= '0;
    end
  endtask

  // Drain the last response, then let the monitor report
  task automatic close_test();
    idle_cycles(2);
    @(posedge clk_sys);
    test_end <= 1'b1;
    @(posedge clk_sys);
    test_end <= 1'b0;
    test_idx <= test_idx + 1;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] v;
    int          ch;
    int          gap;
    logic [7:0]  duty;
    logic [7:0]  period;
    bus_req  = '0;
    gpi      = '0;
    test_end = 1'b0;
    run_end  = 1'b0;
    test_idx = 1;
    seed     = 32'd78163;
    @(posedge rst_n);
    idle_cycles(2);

    // GPIO outputs, writes and reads back to back
    for (int i = 0; i < n_gpo; i++) begin
      r = next_rand();
      send_req(1'b1, r[3:0], reg_addr(`SONATA_DEV_GPIO, 0), next_rand());
      send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_GPIO, 0), next_rand());
    end
    close_test();

    // GPIO inputs through the synchroniser
    for (int i = 0; i < n_gpi; i++) begin
      r = next_rand();
      @(posedge clk_sys);
      gpi <= r[`SONATA_GPI_WIDTH-1:0];
      idle_cycles(4);
      send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_GPIO, 4), 32'h0);
    end
    close_test();

    ////////////////////////////////////////////////////////////////////////////
    // Decode errors, then the real registers once more

    for (int i = 0; i < n_err; i++) begin
      r = next_rand();
      a = r;
      if (i % 2 == 0) a[31:16] = `SONATA_PERIPH_BASE ^ (16'h1 << i);
      else            a = reg_addr(3, int'(r[7:0]) & 'hfc);
      send_req(1'b1, 4'hf, a, next_rand());
      send_req(1'b0, 4'hf, a, 32'h0);
    end
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_GPIO, 0), 32'h0);
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_PWM, 0), 32'h0);
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_TIMER, 8), 32'h0);
    close_test();

    // PWM channels, first one with zero duty
    for (int i = 0; i < n_pwm; i++) begin
      r      = next_rand();
      ch     = int'(r[7:0]) % `SONATA_PWM_WIDTH;
      duty   = (i == 0) ? 8'h00 : r[15:8];
      period = r[23:16];
      send_req(1'b1, 4'h3, reg_addr(`SONATA_DEV_PWM, 4 * ch), {next_rand() & 32'hffff0000}
               | {16'h0, period, duty});
      send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_PWM, 4 * ch), 32'h0);
      idle_cycles(int'(period) + 4);
    end
    close_test();

    ////////////////////////////////////////////////////////////////////////////
    // Timer halves while stopped, then the interrupt after enable

    for (int i = 0; i < n_tmr; i++) begin
      r = next_rand();
      send_req(1'b1, r[3:0], reg_addr(`SONATA_DEV_TIMER, 4 * (i % 4)), next_rand());
      send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_TIMER, 4 * (i % 4)), 32'h0);
      idle_cycles(2);
    end
    r   = next_rand();
    v   = {4'h0, r[27:0]};
    gap = 10 + 2 * int'(r[31:28]);
    send_req(1'b1, 4'hf, reg_addr(`SONATA_DEV_TIMER, 4), 32'h0);
    send_req(1'b1, 4'hf, reg_addr(`SONATA_DEV_TIMER, 0), v);
    send_req(1'b1, 4'hf, reg_addr(`SONATA_DEV_TIMER, 12), 32'h0);
    send_req(1'b1, 4'hf, reg_addr(`SONATA_DEV_TIMER, 8), v + 32'(gap));
    idle_cycles(3);
    send_req(1'b1, 4'hf, reg_addr(`SONATA_DEV_TIMER, 16), 32'h1);
    idle_cycles(gap + 6);
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_TIMER, 0), 32'h0);
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_TIMER, 4), 32'h0);
    send_req(1'b0, 4'hf, reg_addr(`SONATA_DEV_TIMER, 16), 32'h0);
    close_test();

    @(posedge clk_sys);
    run_end <= 1'b1;
    @(posedge clk_sys);
    run_end <= 1'b0;
    @(negedge clk_sys);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
sonata_bus_pkg.sv
sonata_periph_pkg.sv
sonata_bus_decode.sv
sonata_gpio.sv
sonata_pwm.sv
sonata_timer.sv
sonata_system.sv
tb_clk_gen.sv
tb_checker.sv
tb_sonata.sv
